/* Makefile */
# Verilator build and run of the RAM expansion testbench
# Any variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= tb_ram_ext
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: sim clean

# The run passes only if the pass message shows up in the simulator output
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* bank_mapper.sv */
// ==============================
// Maps scheme and quadrant to expansion or internal RAM
// Purely combinational, bank bits are not looked at here
// C3 quadrant 1 needs the overdrive DIP for A15 forcing
// ==============================
`timescale 1ns/1ps

module bank_mapper #(
  parameter int BANK_BITS = 3
) (
  input  ram_ext_pkg::mem_cycle_t  cyc,
  input  ram_ext_pkg::bank_sel_t   bank_sel,
  input  logic                     overdrive,
  output ram_ext_pkg::map_result_t map
);
  import ram_ext_pkg::*;

  logic       exp_sel;
  logic [1:0] block;
  logic       a15_drive;

  // The bank field is three bits, so a wider card cannot be addressed
  if (BANK_BITS < 1 || BANK_BITS > 3) begin : g_bank_bits_check
    $error("BANK_BITS must be between 1 and 3");
  end

  // Quadrant to block table per scheme
  //   scheme   q0  q1  q2  q3
  //   internal -   -   -   -
  //   top      -   -   -   3
  //   all      0   1   2   3
  //   c3       -   *   -   3
  //   winN     -   N   -   -
  // In c3 quadrant 1 stays internal but the gate array is made to see A15 high,
  // so the host reads its own internal block 3 at 0x4000
  always_comb begin
    exp_sel   = 1'b0;
    block     = cyc.quadrant;
    a15_drive = 1'b0;
    case (bank_sel.scheme)
      SCHEME_INTERNAL: begin
        exp_sel = 1'b0;
      end
      SCHEME_TOP: begin
        if (cyc.quadrant == 2'd3) begin
          exp_sel = 1'b1;
          block   = 2'd3;
        end
      end
      SCHEME_ALL: begin
        // Straight through, block follows the quadrant
        exp_sel = 1'b1;
      end
      SCHEME_C3: begin
        if (cyc.quadrant == 2'd3) begin
          exp_sel = 1'b1;
          block   = 2'd3;
        end else if (cyc.quadrant == 2'd1) begin
          a15_drive = overdrive;
        end
      end
      SCHEME_WIN0, SCHEME_WIN1, SCHEME_WIN2, SCHEME_WIN3: begin
        // Low two scheme bits name the block shown in the 0x4000 window
        if (cyc.quadrant == 2'd1) begin
          exp_sel = 1'b1;
          block   = bank_sel.scheme[1:0];
        end
      end
    endcase
  end

  // Older hosts drive rd_b themselves during writes
  // In overdrive mode the card pulls it low so internal RAM stays quiet
  assign map = '{
    exp_sel:   exp_sel,
    block:     block,
    a15_drive: a15_drive,
    rd_drive:  exp_sel && cyc.write && overdrive
  };

endmodule

/* bank_port_decode.sv */
// ==============================
// Bank select port, any I/O write with A15 low and data 11cccbbb
// Address bits other than A15 are not decoded
// The new mapping applies two clocks after the write is sampled
// Overdrive DIP is only read while reset_b is held low
// ==============================
`timescale 1ns/1ps

module bank_port_decode (
  input  logic                   clk,
  input  logic                   reset_b,
  input  ram_ext_pkg::cpc_bus_t  bus,
  input  logic                   dip_overdrive,
  output ram_ext_pkg::bank_sel_t bank_sel,
  output logic                   overdrive
);
  import ram_ext_pkg::*;

  logic       io_sel_now;
  logic       io_sel_q;
  logic       io_sel_d;
  logic       io_wr_stb;
  logic [5:0] wdata_q;

  // Bank select write as seen on the bus right now
  assign io_sel_now = !bus.iorq_b && !bus.wr_b && !bus.adr15
                      && (bus.data[7:6] == BANK_SEL_TAG);

  // Input register for the decode, plus one delayed copy for edge detection
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      io_sel_q <= 1'b0;
      io_sel_d <= 1'b0;
    end else begin
      io_sel_q <= io_sel_now;
      io_sel_d <= io_sel_q;
    end
  end

  // Grab the data byte on the first sample of the write
  // The host may change data later in the I/O cycle so it is held here
  always_ff @(posedge clk) begin
    if (io_sel_now && !io_sel_q) begin
      wdata_q <= bus.data[5:0];
    end
  end

  // One clock wide, on the rising edge of the registered decode
  // A write held over several clocks still fires only once
  assign io_wr_stb = io_sel_q && !io_sel_d;

  // cccbbb lands with ccc in the bank field and bbb in the scheme field
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      bank_sel <= '0;
    end else if (io_wr_stb) begin
      bank_sel <= wdata_q;
    end
  end

  // Tracks the DIP while reset is held, then keeps the last value
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      overdrive <= dip_overdrive;
    end
  end

  // The mapping only moves on a host write, never on its own
  a_bank_sel_only_on_write : assert property (
    @(posedge clk) disable iff (!reset_b)
    $past(reset_b) && !$past(io_wr_stb) |-> $stable(bank_sel)
  ) else $error("bank_sel changed without a bank select write");

endmodule

/* mem_cycle_tracker.sv */
// ==============================
// Follows Z80 memory cycles from the sampled bus
// Outputs lag the bus by one clock
// Refresh cycles are never marked active
// Quadrant is frozen at cycle start
// ==============================
`timescale 1ns/1ps

module mem_cycle_tracker (
  input  logic                    clk,
  input  logic                    reset_b,
  input  ram_ext_pkg::cpc_bus_t   bus,
  output ram_ext_pkg::mem_cycle_t cyc,
  output ram_ext_pkg::cpc_bus_t   bus_q
);
  import ram_ext_pkg::*;

  logic       start_now;
  logic       write_d;
  logic       first_q;
  logic       active_q;
  logic       write_q;
  logic [1:0] quadrant_q;

  // bus_q.mreq_b holds the previous mreq level, so a fall is seen here
  assign start_now = !bus.mreq_b && bus_q.mreq_b && bus.rfsh_b;

  // Write flag rules
  // At cycle start a read shows rd_b or m1_b low, otherwise it is a write,
  // which lets the flag be set before the late wr_b strobe arrives
  always_comb begin
    write_d = write_q;
    if (bus.mreq_b) begin
      write_d = 1'b0;
    end else if (start_now) begin
      write_d = !bus.wr_b || (bus.rd_b && bus.m1_b);
    end else if (!bus.wr_b && bus.rfsh_b) begin
      // wr_b falling partway through the cycle
      write_d = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_b) begin
      // All strobes inactive
      bus_q      <= '1;
      first_q    <= 1'b0;
      active_q   <= 1'b0;
      write_q    <= 1'b0;
      quadrant_q <= 2'd0;
    end else begin
      bus_q    <= bus;
      first_q  <= start_now;
      active_q <= !bus.mreq_b && bus.rfsh_b;
      write_q  <= write_d;
      // A15 is only trusted at mreq fall, a driven A15 must not move the quadrant
      if (start_now) begin
        quadrant_q <= {bus.adr15, bus.adr14};
      end
    end
  end

  assign cyc = '{
    active:   active_q,
    write:    write_q,
    first:    first_q,
    quadrant: quadrant_q,
    rd_b:     bus_q.rd_b
  };

  // mreq must rise again before another cycle can start
  a_first_single : assert property (
    @(posedge clk) disable iff (!reset_b)
    first_q |=> !first_q
  ) else $error("first asserted on two consecutive clocks");

endmodule

/* ram_ext_pkg.sv */
// ==============================
// Shared types for the RAM expansion control logic
// Bus fields keep the Z80 active-low naming of the host connector
// bank_sel_t packs cccbbb with ccc in the upper three bits
// ==============================
package ram_ext_pkg;

  // One clock's sample of the host bus, address bit 8 is carried but not decoded
  typedef struct packed {
    logic       mreq_b;
    logic       iorq_b;
    logic       wr_b;
    logic       rd_b;
    logic       m1_b;
    logic       rfsh_b;
    logic       adr15;
    logic       adr14;
    logic       adr8;
    logic [7:0] data;
  } cpc_bus_t;

  // Bank select register as written by the host, cccbbb
  typedef struct packed {
    logic [2:0] bank;
    logic [2:0] scheme;
  } bank_sel_t;

  // Tracker view of the current memory cycle
  typedef struct packed {
    logic       active;
    logic       write;
    logic       first;
    logic [1:0] quadrant;
    logic       rd_b;
  } mem_cycle_t;

  // Mapper decision for the current quadrant
  typedef struct packed {
    logic       exp_sel;
    logic [1:0] block;
    logic       a15_drive;
    logic       rd_drive;
  } map_result_t;

  // Registered RAM controls and bus drive requests
  typedef struct packed {
    logic ramcs_b;
    logic ramoe_b;
    logic ramwe_b;
    logic ramdis;
    logic drive_rd_low;
    logic drive_a15_high;
  } ram_ctl_t;

  // Strobes inactive, internal RAM enabled and nothing driven on the bus
  localparam ram_ctl_t RAM_CTL_IDLE = '{
    ramcs_b: 1'b1, ramoe_b: 1'b1, ramwe_b: 1'b1,
    ramdis: 1'b0, drive_rd_low: 1'b0, drive_a15_high: 1'b0
  };

  // Data bits 7..6 of an I/O write must carry this tag to load the bank select
  localparam logic [1:0] BANK_SEL_TAG = 2'b11;

  // Block switching schemes, the bbb field
  localparam logic [2:0] SCHEME_INTERNAL = 3'd0;
  localparam logic [2:0] SCHEME_TOP      = 3'd1;
  localparam logic [2:0] SCHEME_ALL      = 3'd2;
  localparam logic [2:0] SCHEME_C3       = 3'd3;
  localparam logic [2:0] SCHEME_WIN0     = 3'd4;
  localparam logic [2:0] SCHEME_WIN1     = 3'd5;
  localparam logic [2:0] SCHEME_WIN2     = 3'd6;
  localparam logic [2:0] SCHEME_WIN3     = 3'd7;

endpackage

/* ram_ext_top.sv */
// ==============================
// RAM expansion control, top level
// BANK_BITS 3 for a 512K card, 2 for 256K
// Drive requests stand in for the tristate pins
// Bus to RAM control latency is two clocks
// ==============================
`timescale 1ns/1ps

module ram_ext_top #(
  parameter int BANK_BITS = 3
) (
  input  logic                  clk,
  input  logic                  reset_b,
  input  ram_ext_pkg::cpc_bus_t bus,
  input  logic                  dip_overdrive,
  output ram_ext_pkg::ram_ctl_t ram_ctl,
  output logic [BANK_BITS+1:0]  ramadrhi
);
  import ram_ext_pkg::*;

  bank_sel_t   bank_sel;
  logic        overdrive;
  mem_cycle_t  cyc;
  map_result_t map;

  // Bank select port and overdrive DIP latch
  bank_port_decode u_port (
    .clk           (clk),
    .reset_b       (reset_b),
    .bus           (bus),
    .dip_overdrive (dip_overdrive),
    .bank_sel      (bank_sel),
    .overdrive     (overdrive)
  );

  // Memory cycle tracking, the registered bus copy is only used inside
  mem_cycle_tracker u_cycle (
    .clk     (clk),
    .reset_b (reset_b),
    .bus     (bus),
    .cyc     (cyc),
    .bus_q   ()
  );

  // Scheme and quadrant to block
  bank_mapper #(
    .BANK_BITS (BANK_BITS)
  ) u_map (
    .cyc       (cyc),
    .bank_sel  (bank_sel),
    .overdrive (overdrive),
    .map       (map)
  );

  // Registered RAM strobes and high address
  ram_strobe_gen #(
    .BANK_BITS (BANK_BITS)
  ) u_strobe (
    .clk      (clk),
    .reset_b  (reset_b),
    .cyc      (cyc),
    .map      (map),
    .bank_sel (bank_sel),
    .ram_ctl  (ram_ctl),
    .ramadrhi (ramadrhi)
  );

endmodule

/* ram_strobe_gen.sv */
// ==============================
// Registers the RAM strobes and drive requests
// One clock behind the tracker outputs
// Only the low BANK_BITS of the bank reach the RAM address
// ==============================
`timescale 1ns/1ps

module ram_strobe_gen #(
  parameter int BANK_BITS = 3
) (
  input  logic                     clk,
  input  logic                     reset_b,
  input  ram_ext_pkg::mem_cycle_t  cyc,
  input  ram_ext_pkg::map_result_t map,
  input  ram_ext_pkg::bank_sel_t   bank_sel,
  output ram_ext_pkg::ram_ctl_t    ram_ctl,
  output logic [BANK_BITS+1:0]     ramadrhi
);
  import ram_ext_pkg::*;

  logic cs;

  // Expansion RAM access in a real memory cycle, refresh excluded by the tracker
  assign cs = cyc.active && map.exp_sel;

  always_ff @(posedge clk) begin
    if (!reset_b) begin
      ram_ctl <= RAM_CTL_IDLE;
    end else begin
      ram_ctl.ramcs_b <= !cs;
      ram_ctl.ramwe_b <= !(cs && cyc.write);
      // Output enable follows the host read strobe
      ram_ctl.ramoe_b <= !(cs && !cyc.rd_b);
      // Internal RAM is switched off whenever the card answers
      ram_ctl.ramdis  <= cs;
      ram_ctl.drive_rd_low   <= cyc.active && map.rd_drive;
      ram_ctl.drive_a15_high <= cyc.active && map.a15_drive;
    end
  end

  // Upper RAM address is bank then block, bank bits above BANK_BITS dropped
  always_ff @(posedge clk) begin
    ramadrhi <= {bank_sel.bank[BANK_BITS-1:0], map.block};
  end

  // Chip select without the internal-RAM disable would put two RAMs on the bus
  a_cs_needs_ramdis : assert property (
    @(posedge clk) disable iff (!reset_b)
    !ram_ctl.ramcs_b |-> ram_ctl.ramdis
  ) else $error("ramcs_b low while ramdis low");

  // A write strobe is only meaningful with the chip selected
  a_we_needs_cs : assert property (
    @(posedge clk) disable iff (!reset_b)
    !ram_ctl.ramwe_b |-> !ram_ctl.ramcs_b
  ) else $error("ramwe_b low while ramcs_b high");

endmodule

/* sources.f */
ram_ext_pkg.sv
bank_port_decode.sv
mem_cycle_tracker.sv
bank_mapper.sv
ram_strobe_gen.sv
ram_ext_top.sv
tb_ram_ext.sv

/* tb_ram_ext.sv */
// ==============================
// Directed testbench for the RAM expansion control top level
// Outputs are checked two clocks after each sampled bus cycle
// Bank select writes are followed by idle cycles before any access
// Expected values come from a reference of the scheme table
// ==============================
`timescale 1ns/1ps

module tb_ram_ext;
  import ram_ext_pkg::*;

  localparam int BANK_BITS     = 3;
  localparam int CLK_PERIOD    = 8;
  localparam int ACCESS_LEN    = 3;
  localparam int MARGIN_CYCLES = 100;
  // Rough clock counts per test, an access costs 6 clocks and a port write 7
  localparam int TEST_CYCLES   = 40 + 260 + 100 + 70 + 60 + 100;

  logic                 clk;
  logic                 reset_b;
  cpc_bus_t             bus;
  logic                 dip_overdrive;
  ram_ctl_t             ram_ctl;
  logic [BANK_BITS+1:0] ramadrhi;

  // What the card should currently hold
  logic [2:0] model_bank;
  logic [2:0] model_scheme;
  logic       model_od;

  int checks;
  int errors;

  ram_ext_top #(
    .BANK_BITS (BANK_BITS)
  ) u_dut (
    .clk           (clk),
    .reset_b       (reset_b),
    .bus           (bus),
    .dip_overdrive (dip_overdrive),
    .ram_ctl       (ram_ctl),
    .ramadrhi      (ramadrhi)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Stops a run that hangs on a stuck task
  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d clock cycles",
             TEST_CYCLES + MARGIN_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // Bus with every strobe inactive
  function automatic cpc_bus_t idle_bus();
    cpc_bus_t b;
    b = '0;
    b.mreq_b = 1'b1;
    b.iorq_b = 1'b1;
    b.wr_b   = 1'b1;
    b.rd_b   = 1'b1;
    b.m1_b   = 1'b1;
    b.rfsh_b = 1'b1;
    return b;
  endfunction

  // Scheme table of the card, written out per scheme
  function automatic map_result_t ref_map(input logic [2:0] scheme, input logic [1:0] quad,
                                          input logic wr, input logic od);
    map_result_t r;
    r = '0;
    if (scheme == SCHEME_ALL) begin
      r.exp_sel = 1'b1;
      r.block   = quad;
    end else if ((scheme == SCHEME_TOP || scheme == SCHEME_C3) && quad == 2'd3) begin
      r.exp_sel = 1'b1;
      r.block   = 2'd3;
    end else if (scheme >= SCHEME_WIN0 && quad == 2'd1) begin
      // The window schemes put block n at 0x4000
      r.exp_sel = 1'b1;
      r.block   = 2'(scheme - SCHEME_WIN0);
    end
    if (scheme == SCHEME_C3 && quad == 2'd1) begin
      r.a15_drive = od;
    end
    r.rd_drive = r.exp_sel && wr && od;
    return r;
  endfunction

  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  // Compares all outputs with the expected map of one access
  task automatic check_outputs(input map_result_t e, input logic wr);
    check_value("ramcs_b", 8'(ram_ctl.ramcs_b), 8'(!e.exp_sel));
    check_value("ramdis", 8'(ram_ctl.ramdis), 8'(e.exp_sel));
    check_value("ramwe_b", 8'(ram_ctl.ramwe_b), 8'(!(e.exp_sel && wr)));
    check_value("ramoe_b", 8'(ram_ctl.ramoe_b), 8'(!(e.exp_sel && !wr)));
    check_value("drive_rd_low", 8'(ram_ctl.drive_rd_low), 8'(e.rd_drive));
    check_value("drive_a15_high", 8'(ram_ctl.drive_a15_high), 8'(e.a15_drive));
    // The high address only matters while the card is selected
    if (e.exp_sel) begin
      check_value("ramadrhi", 8'(ramadrhi), 8'({model_bank[BANK_BITS-1:0], e.block}));
    end
  endtask

  // Reset with the overdrive DIP set, then the DIP moves to show it is latched
  task automatic apply_reset(input logic od);
    @(posedge clk);
    reset_b       <= 1'b0;
    dip_overdrive <= od;
    bus           <= idle_bus();
    repeat (4) @(posedge clk);
    reset_b       <= 1'b1;
    dip_overdrive <= !od;
    model_bank   = 3'd0;
    model_scheme = SCHEME_INTERNAL;
    model_od     = od;
    repeat (2) @(posedge clk);
  endtask

  // I/O write held for two clocks, then idle so the new mapping settles
  task automatic io_write(input logic adr15, input logic [7:0] data);
    cpc_bus_t b;
    b        = idle_bus();
    b.iorq_b = 1'b0;
    b.wr_b   = 1'b0;
    b.adr15  = adr15;
    b.adr14  = 1'($urandom);
    b.adr8   = 1'b1;
    b.data   = data;
    @(posedge clk);
    bus <= b;
    repeat (2) @(posedge clk);
    bus <= idle_bus();
    repeat (4) @(posedge clk);
    if (!adr15 && data[7:6] == 2'b11) begin
      model_bank   = data[5:3];
      model_scheme = data[2:0];
    end
  endtask

  task automatic select_mapping(input logic [2:0] bank, input logic [2:0] scheme);
    io_write(1'b0, {2'b11, bank, scheme});
  endtask

  // Memory cycle of ACCESS_LEN clocks in one quadrant, checked on every clock
  task automatic mem_access(input logic [1:0] quad, input logic wr, input logic refresh);
    cpc_bus_t    b;
    map_result_t e;
    b        = idle_bus();
    b.mreq_b = 1'b0;
    b.rd_b   = wr || refresh;
    b.wr_b   = !wr;
    b.m1_b   = !refresh;
    b.rfsh_b = !refresh;
    b.adr15  = quad[1];
    b.adr14  = quad[0];
    b.adr8   = 1'($urandom);
    b.data   = 8'($urandom);
    e = refresh ? '0 : ref_map(model_scheme, quad, wr, model_od);
    @(posedge clk);
    bus <= b;
    for (int i = 0; i <= ACCESS_LEN; i++) begin
      @(posedge clk);
      if (i == ACCESS_LEN - 1) begin
        bus <= idle_bus();
      end
      // Each check sees the sample taken two clocks earlier
      if (i >= 1) begin
        @(negedge clk);
        check_outputs(e, wr);
      end
    end
    @(posedge clk);
    @(negedge clk);
    check_value("ramcs_b after cycle", 8'(ram_ctl.ramcs_b), 8'd1);
    check_value("ramwe_b after cycle", 8'(ram_ctl.ramwe_b), 8'd1);
  endtask

  task automatic reset_reads_internal();
    for (int q = 0; q < 4; q++) mem_access(2'(q), 1'b0, 1'b0);
  endtask

  task automatic scheme_sweep();
    for (int s = 0; s < 8; s++) begin
      select_mapping(3'($urandom_range(7, 0)), 3'(s));
      for (int q = 0; q < 4; q++) mem_access(2'(q), 1'b0, 1'b0);
    end
  endtask

  // Writes with and without overdrive, plus a read that must not pull rd_b
  task automatic expansion_writes();
    for (int od = 0; od < 2; od++) begin
      apply_reset(1'(od));
      select_mapping(3'($urandom_range(7, 0)), SCHEME_ALL);
      for (int q = 0; q < 4; q++) mem_access(2'(q), 1'b1, 1'b0);
      mem_access(2'd2, 1'b0, 1'b0);
    end
  endtask

  task automatic c3_overdrive();
    for (int od = 1; od >= 0; od--) begin
      apply_reset(1'(od));
      select_mapping(3'($urandom_range(7, 0)), SCHEME_C3);
      mem_access(2'd1, 1'b0, 1'b0);
      mem_access(2'd1, 1'b1, 1'b0);
      mem_access(2'd3, 1'b0, 1'b0);
    end
  endtask

  // Wrong tag or A15 high must leave the top scheme in place
  task automatic ignored_io_writes();
    select_mapping(3'($urandom_range(7, 0)), SCHEME_TOP);
    io_write(1'b0, {2'b10, 3'd5, SCHEME_ALL});
    io_write(1'b1, {2'b11, 3'd6, SCHEME_ALL});
    io_write(1'b0, {2'b01, 3'd7, SCHEME_WIN1});
    for (int q = 0; q < 4; q++) mem_access(2'(q), 1'b0, 1'b0);
  endtask

  task automatic refresh_never_selects();
    select_mapping(3'($urandom_range(7, 0)), SCHEME_ALL);
    for (int q = 0; q < 4; q++) mem_access(2'(q), 1'b0, 1'b1);
    select_mapping(3'($urandom_range(7, 0)), SCHEME_TOP);
    for (int q = 0; q < 4; q++) mem_access(2'(q), 1'b0, 1'b1);
    select_mapping(3'($urandom_range(7, 0)), SCHEME_WIN2);
    for (int q = 0; q < 4; q++) mem_access(2'(q), 1'b0, 1'b1);
  endtask

  initial begin
    checks        = 0;
    errors        = 0;
    bus           = idle_bus();
    reset_b       = 1'b0;
    dip_overdrive = 1'b0;
    void'($urandom(32'h75c6_bb60));
    apply_reset(1'b0);
    reset_reads_internal();
    scheme_sweep();
    expansion_writes();
    c3_overdrive();
    ignored_io_writes();
    refresh_never_selects();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
